/* vuad_array.f */
src/vuad_pkg.sv
src/vuad_ctl.sv
src/vuad_subarray.sv
src/vuad_rd_mux.sv
src/vuad_array.sv
verification/vuad_array_tb.sv

/* Makefile */
# Verilator build and run of the vuad state array testbench

VERILATOR ?= verilator
TOP       ?= vuad_array_tb
FILELIST  ?= vuad_array.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   list these targets"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Testbench failed" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* verification/vuad_array_tb.sv */
/*
 * vuad state array testbench
 * reference model with an expected-response queue, directed and random
 * stimulus, concurrent checks on the response and handshake
 */
module vuad_array_tb;

   localparam int WORD_W     = 6;
   localparam int DATA_W     = 2 * WORD_W;
   localparam int CLK_PERIOD = 40;

   // cycle budget of each test, summed for the watchdog
   localparam int RESET_CYC  = 10;
   localparam int FULL_CYC   = 90;
   localparam int COL_CYC    = 20;
   localparam int SEL_CYC    = 16;
   localparam int STALL_CYC  = 240;
   localparam int SAME_CYC   = 12;
   localparam int MARGIN_CYC = 100;
   localparam int TEST_CYC   = RESET_CYC + FULL_CYC + COL_CYC + SEL_CYC + STALL_CYC + SAME_CYC;

   typedef struct packed {
      vuad_pkg::index_t    addr;
      logic [1:0]          col_en;  // bit 0 low column
      logic [DATA_W-1:0]   data;
   } wr_req_t;

   logic                 rclk;
   logic                 reset;
   vuad_pkg::rd_req_t    rd_req;
   logic                 rd_req_valid;
   logic                 rd_req_ready;
   wr_req_t              wr_req;
   logic                 wr_valid;
   logic [DATA_W-1:0]    rd_data;
   logic                 rd_valid;
   logic                 rd_ready;

   logic [1:0][WORD_W-1:0] model [1024];  // reference, one entry per index
   logic [DATA_W-1:0]      exp_q [$];
   logic [DATA_W-1:0]      exp_head;
   logic [DATA_W-1:0]      prev_data;
   int                     exp_count;
   vuad_pkg::index_t       written [32];
   logic                   stall_mode;
   string                  test_name;
   int                     seed;
   int                     err_count;
   int                     err_mark;
   int                     test_count;
   int                     read_count;
   int                     check_count;

   vuad_array #(.WORD_W(WORD_W)) uut (
      .rclk         (rclk),
      .reset        (reset),
      .rd_req       (rd_req),
      .rd_req_valid (rd_req_valid),
      .rd_req_ready (rd_req_ready),
      .wr_req       (wr_req),
      .wr_valid     (wr_valid),
      .rd_data      (rd_data),
      .rd_valid     (rd_valid),
      .rd_ready     (rd_ready)
   );

   always #(CLK_PERIOD / 2) rclk = ~rclk;

   ////////////////////////////////////////
   // reference model and expected queue
   ////////////////////////////////////////

   // pre-edge values, the DUT only changes them in the NBA region
   always @(posedge rclk) begin
      if (reset) begin
         exp_q.delete();
      end else begin
         if (rd_valid && rd_ready && exp_q.size() > 0) begin
            exp_q.delete(0);
            check_count++;
         end
         if (rd_req_valid && rd_req_ready) begin  // old data, before this edge's write
            exp_q.push_back(model[rd_req.addr_sel ? rd_req.addr1 : rd_req.addr2]);
         end
      end
      if (wr_valid) begin
         if (wr_req.col_en[0]) model[wr_req.addr][0] = wr_req.data[WORD_W-1:0];
         if (wr_req.col_en[1]) model[wr_req.addr][1] = wr_req.data[DATA_W-1:WORD_W];
      end
      exp_count = exp_q.size();
      exp_head  = (exp_count > 0) ? exp_q[0] : '0;
      prev_data = rd_data;
   end

   ////////////////////////////////////////
   // checks
   ////////////////////////////////////////

   a_reset_state : assert property (@(posedge rclk)
      reset |=> (!rd_valid && rd_req_ready))
      else begin
         $display("CHECK FAILED %s: rd_valid/rd_req_ready expected 0/1, actual %b/%b",
                  test_name, $sampled(rd_valid), $sampled(rd_req_ready));
         err_count++;
      end

   a_resp_present : assert property (@(posedge rclk) disable iff (reset)
      (rd_valid && rd_ready) |-> (exp_count > 0))
      else begin
         $display("%s: a response was taken with no read outstanding", test_name);
         err_count++;
      end

   a_resp_data : assert property (@(posedge rclk) disable iff (reset)
      (rd_valid && rd_ready && exp_count > 0) |-> (rd_data == exp_head))
      else begin
         $display("CHECK FAILED %s: rd_data expected %h, actual %h",
                  test_name, $sampled(exp_head), $sampled(rd_data));
         err_count++;
      end

   // response two cycles after the accepting edge
   a_latency : assert property (@(posedge rclk) disable iff (reset)
      (rd_req_valid && rd_req_ready) |-> ##2 rd_valid)
      else begin
         $display("CHECK FAILED %s: rd_valid two cycles after accept expected 1, actual %b",
                  test_name, $sampled(rd_valid));
         err_count++;
      end

   a_ready_idle : assert property (@(posedge rclk) disable iff (reset)
      !rd_valid |-> rd_req_ready)
      else begin
         $display("CHECK FAILED %s: rd_req_ready with empty response expected 1, actual %b",
                  test_name, $sampled(rd_req_ready));
         err_count++;
      end

   a_stall_ready : assert property (@(posedge rclk) disable iff (reset)
      (rd_valid && !rd_ready) |-> !rd_req_ready)
      else begin
         $display("CHECK FAILED %s: rd_req_ready while stalled expected 0, actual %b",
                  test_name, $sampled(rd_req_ready));
         err_count++;
      end

   a_stall_hold : assert property (@(posedge rclk) disable iff (reset)
      (rd_valid && !rd_ready) |=> (rd_valid && $stable(rd_data)))
      else begin
         $display("CHECK FAILED %s: held rd_data expected %h, actual %h",
                  test_name, $sampled(prev_data), $sampled(rd_data));
         err_count++;
      end

   ////////////////////////////////////////
   // stimulus tasks
   ////////////////////////////////////////

   // all inputs move on the falling edge
   task automatic next_fall();
      logic [31:0] r;
      @(negedge rclk);
      if (stall_mode) begin
         r        = $random(seed);
         rd_ready = r[0];
      end
   endtask

   task automatic write_word(input vuad_pkg::index_t idx, input logic [1:0] col_en,
                             input logic [DATA_W-1:0] data);
      wr_req.addr   = idx;
      wr_req.col_en = col_en;
      wr_req.data   = data;
      wr_valid      = 1'b1;
      next_fall();
      wr_valid      = 1'b0;
   endtask

   task automatic read_req(input vuad_pkg::index_t a1, input vuad_pkg::index_t a2,
                           input logic sel);
      logic accepted;
      accepted        = 1'b0;
      rd_req.addr1    = a1;
      rd_req.addr2    = a2;
      rd_req.addr_sel = sel;
      rd_req_valid    = 1'b1;
      while (!accepted) begin
         @(posedge rclk);
         accepted = rd_req_ready;  // sampled before the edge updates
         next_fall();
      end
      rd_req_valid = 1'b0;
      read_count++;
   endtask

   // write and read of one index at the same edge
   task automatic write_and_read(input vuad_pkg::index_t idx, input logic [DATA_W-1:0] data);
      wr_req.addr     = idx;
      wr_req.col_en   = 2'b11;
      wr_req.data     = data;
      wr_valid        = 1'b1;
      rd_req.addr1    = idx;
      rd_req.addr2    = ~idx;
      rd_req.addr_sel = 1'b1;
      rd_req_valid    = 1'b1;  // accepted at once, the response path is empty
      next_fall();
      wr_valid        = 1'b0;
      rd_req_valid    = 1'b0;
      read_count++;
   endtask

   task automatic drain();
      while (exp_count != 0) begin
         next_fall();
      end
   endtask

   task automatic start_test(input string name);
      test_name = name;
      err_mark  = err_count;
   endtask

   task automatic end_test();
      test_count++;
      $display("test %-16s done, %0d errors", test_name, err_count - err_mark);
   endtask

   ////////////////////////////////////////
   // test sequence
   ////////////////////////////////////////

   initial begin
      logic [31:0]       r;
      vuad_pkg::index_t  idx;
      vuad_pkg::index_t  idx_b;
      logic [DATA_W-1:0] data;
      rclk         = 1'b0;
      reset        = 1'b1;
      rd_req       = '0;
      rd_req_valid = 1'b0;
      wr_req       = '0;
      wr_valid     = 1'b0;
      rd_ready     = 1'b1;
      stall_mode   = 1'b0;
      seed         = 89269;
      err_count    = 0;
      test_count   = 0;
      read_count   = 0;
      check_count  = 0;
      exp_count    = 0;

      start_test("reset");
      repeat (5) @(posedge rclk);
      next_fall();
      reset = 1'b0;
      repeat (2) next_fall();
      end_test();

      // every subarray and word, entry and data random
      start_test("full_write_read");
      for (int s = 0; s < vuad_pkg::NUM_SUB; s++) begin
         for (int w = 0; w < vuad_pkg::NUM_WORD; w++) begin
            r   = $random(seed);
            idx = {s[2:0], r[16:12], w[1:0]};
            written[s*4 + w] = idx;
            write_word(idx, 2'b11, r[DATA_W-1:0]);
         end
      end
      for (int i = 0; i < 32; i++) begin
         read_req(written[i], ~written[i], 1'b1);
      end
      drain();
      end_test();

      start_test("column_write");
      r = $random(seed);
      idx = r[9:0];
      write_word(idx, 2'b11, r[31:20]);
      r = $random(seed);
      write_word(idx, 2'b01, r[DATA_W-1:0]);  // low half only
      read_req(idx, idx, 1'b1);
      drain();
      r = $random(seed);
      write_word(idx, 2'b10, r[DATA_W-1:0]);  // high half only
      read_req(idx, idx, 1'b1);
      drain();
      end_test();

      start_test("addr_select");
      r     = $random(seed);
      idx   = r[9:0];
      idx_b = idx ^ 10'h2b6;
      write_word(idx, 2'b11, r[DATA_W-1:0]);
      write_word(idx_b, 2'b11, ~r[DATA_W-1:0]);
      read_req(idx, idx_b, 1'b0);
      read_req(idx_b, idx, 1'b0);
      drain();
      end_test();

      // back-to-back reads with random rd_ready
      start_test("backpressure");
      stall_mode = 1'b1;
      for (int i = 0; i < 40; i++) begin
         r = $random(seed);
         read_req(written[r[4:0]], written[r[10:6]], r[5]);
      end
      drain();
      stall_mode = 1'b0;
      rd_ready   = 1'b1;
      next_fall();
      end_test();

      start_test("same_cycle_rw");
      idx  = written[5];
      data = ~model[idx];
      write_and_read(idx, data);
      read_req(idx, idx, 1'b1);
      drain();
      end_test();

      if (check_count != read_count) begin
         $display("responses checked (%0d) do not match reads issued (%0d)",
                  check_count, read_count);
      end
      $display("summary: %0d tests, %0d reads, %0d responses checked, %0d errors",
               test_count, read_count, check_count, err_count);
      if (err_count == 0 && check_count == read_count) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

   // watchdog
   initial begin
      #((TEST_CYC + MARGIN_CYC) * CLK_PERIOD);
      $display("timeout: the tests did not finish in %0d cycles", TEST_CYC + MARGIN_CYC);
      $display("Testbench failed");
      $finish;
   end

endmodule

/* src/vuad_array.sv */
/*
 * vuad state array, one cache bank
 * control block, eight subarrays and the read mux
 */
module vuad_array #(
   parameter int WORD_W = 6,
   localparam int WR_REQ_W = $bits(vuad_pkg::index_t) + 2 + 2 * WORD_W
) (
   input  logic                 rclk,
   input  logic                 reset,
   input  vuad_pkg::rd_req_t    rd_req,
   input  logic                 rd_req_valid,
   output logic                 rd_req_ready,
   input  logic [WR_REQ_W-1:0]  wr_req,
   input  logic                 wr_valid,
   output logic [2*WORD_W-1:0]  rd_data,
   output logic                 rd_valid,
   input  logic                 rd_ready
);

   vuad_pkg::sub_ctl_t [vuad_pkg::NUM_SUB-1:0] sub_ctl;
   logic [2*WORD_W-1:0]                        wr_data;
   vuad_pkg::mux_sel_t                         mux_sel;
   logic                                       rd_valid_c1;
   logic                                       advance;
   logic [vuad_pkg::NUM_SUB-1:0][vuad_pkg::NUM_WORD-1:0][2*WORD_W-1:0] sub_words;

   vuad_ctl #(.WORD_W(WORD_W)) u_ctl (
      .rclk         (rclk),
      .reset        (reset),
      .rd_req       (rd_req),
      .rd_req_valid (rd_req_valid),
      .rd_req_ready (rd_req_ready),
      .wr_req       (wr_req),
      .wr_valid     (wr_valid),
      .advance      (advance),
      .sub_ctl      (sub_ctl),
      .wr_data      (wr_data),
      .mux_sel      (mux_sel),
      .rd_valid_c1  (rd_valid_c1)
   );

   // subarray i sits at index bits 9:7 == i
   for (genvar i = 0; i < vuad_pkg::NUM_SUB; i++) begin : g_subarray
      vuad_subarray #(.WORD_W(WORD_W)) u_sub (
         .rclk     (rclk),
         .ctl      (sub_ctl[i]),
         .wr_data  (wr_data),
         .rd_words (sub_words[i])
      );
   end

   vuad_rd_mux #(.WORD_W(WORD_W)) u_rd_mux (
      .rclk        (rclk),
      .reset       (reset),
      .sub_words   (sub_words),
      .mux_sel     (mux_sel),
      .rd_valid_c1 (rd_valid_c1),
      .rd_ready    (rd_ready),
      .rd_valid    (rd_valid),
      .rd_data     (rd_data),
      .advance     (advance)
   );

endmodule

/* src/vuad_rd_mux.sv */
/*
 * vuad read mux
 * word, odd and pair selection of the subarray outputs,
 * then the response register with valid/ready
 */
module vuad_rd_mux #(
   parameter int WORD_W = 6
) (
   input  logic                                rclk,
   input  logic                                reset,
   input  logic [vuad_pkg::NUM_SUB-1:0][vuad_pkg::NUM_WORD-1:0][2*WORD_W-1:0] sub_words,
   input  vuad_pkg::mux_sel_t                  mux_sel,
   input  logic                                rd_valid_c1,
   input  logic                                rd_ready,
   output logic                                rd_valid,
   output logic [2*WORD_W-1:0]                 rd_data,
   output logic                                advance
);

   logic [vuad_pkg::NUM_SUB-1:0][2*WORD_W-1:0]  col_word;   // per subarray
   logic [vuad_pkg::NUM_PAIR-1:0][2*WORD_W-1:0] pair_word;
   logic [2*WORD_W-1:0]                         rd_data_c1;

   ////////////////////////////////////////
   // word select, one-hot and-or
   ////////////////////////////////////////

   always_comb begin
      for (int s = 0; s < vuad_pkg::NUM_SUB; s++) begin
         col_word[s] = '0;
         for (int w = 0; w < vuad_pkg::NUM_WORD; w++) begin
            col_word[s] = col_word[s] | (sub_words[s][w] & {2*WORD_W{mux_sel.word_en[w]}});
         end
      end
   end

   ////////////////////////////////////////
   // odd select, then pair select
   ////////////////////////////////////////

   always_comb begin
      for (int p = 0; p < vuad_pkg::NUM_PAIR; p++) begin
         pair_word[p] = mux_sel.odd ? col_word[2*p+1] : col_word[2*p];
      end
   end

   always_comb begin
      rd_data_c1 = '0;
      for (int p = 0; p < vuad_pkg::NUM_PAIR; p++) begin
         rd_data_c1 = rd_data_c1 | (pair_word[p] & {2*WORD_W{mux_sel.pair[p]}});
      end
   end

   ////////////////////////////////////////
   // response register
   ////////////////////////////////////////

   // empty, or being taken this cycle
   assign advance = ~rd_valid | rd_ready;

   always_ff @(posedge rclk) begin
      if (reset) begin
         rd_valid <= 1'b0;
      end else if (advance) begin
         rd_valid <= rd_valid_c1;
      end
   end

   always_ff @(posedge rclk) begin
      if (advance) begin
         rd_data <= rd_data_c1;
      end
   end

   // selects come from the control block one cycle earlier
   a_sel_onehot : assert property (@(posedge rclk) disable iff (reset)
      rd_valid_c1 |-> ($onehot(mux_sel.pair) && $onehot(mux_sel.word_en)))
      else $error("vuad_rd_mux: pair or word select not one-hot");

   a_rd_hold : assert property (@(posedge rclk) disable iff (reset)
      (rd_valid && !rd_ready) |=> (rd_valid && $stable(rd_data)))
      else $error("vuad_rd_mux: response changed while stalled");

endmodule

/* src/vuad_subarray.sv */
/*
 * vuad subarray
 * 32 entries of four words, two columns each, with a registered read port
 */
module vuad_subarray #(
   parameter int WORD_W = 6
) (
   input  logic                                            rclk,
   input  vuad_pkg::sub_ctl_t                              ctl,
   input  logic [2*WORD_W-1:0]                             wr_data,
   output logic [vuad_pkg::NUM_WORD-1:0][2*WORD_W-1:0]     rd_words
);

   // storage, column 0 is the low half of a word
   logic [1:0][WORD_W-1:0] mem [vuad_pkg::NUM_ENTRY][vuad_pkg::NUM_WORD];

   ////////////////////////////////////////
   // write port
   ////////////////////////////////////////

   always_ff @(posedge rclk) begin
      for (int w = 0; w < vuad_pkg::NUM_WORD; w++) begin
         for (int c = 0; c < 2; c++) begin
            if (ctl.wr_word_en[w] && ctl.wr_col_en[c]) begin
               mem[ctl.wr_entry][w][c] <= wr_data[c*WORD_W +: WORD_W];
            end
         end
      end
   end

   ////////////////////////////////////////
   // read port
   ////////////////////////////////////////

   // whole entry is read, the word is picked later in the mux
   // same-edge write is not seen here, old data comes out
   always_ff @(posedge rclk) begin
      if (ctl.rd_en) begin
         for (int w = 0; w < vuad_pkg::NUM_WORD; w++) begin
            rd_words[w] <= mem[ctl.rd_entry][w];
         end
      end
   end

   a_rd_entry_known : assert property (@(posedge rclk)
      ctl.rd_en |-> !$isunknown(ctl.rd_entry))
      else $error("vuad_subarray: read entry unknown while rd_en is set");

endmodule

/* src/vuad_ctl.sv */
/*
 * vuad control
 * decodes read and write indices into per-subarray controls,
 * registers the read mux selects and the stage c1 valid
 */
module vuad_ctl #(
   parameter int WORD_W = 6,
   localparam int WR_REQ_W = $bits(vuad_pkg::index_t) + 2 + 2 * WORD_W
) (
   input  logic                                         rclk,
   input  logic                                         reset,
   input  vuad_pkg::rd_req_t                            rd_req,
   input  logic                                         rd_req_valid,
   output logic                                         rd_req_ready,
   input  logic [WR_REQ_W-1:0]                          wr_req,
   input  logic                                         wr_valid,
   input  logic                                         advance,
   output vuad_pkg::sub_ctl_t [vuad_pkg::NUM_SUB-1:0]   sub_ctl,
   output logic [2*WORD_W-1:0]                          wr_data,
   output vuad_pkg::mux_sel_t                           mux_sel,
   output logic                                         rd_valid_c1
);

   typedef struct packed {
      vuad_pkg::index_t    addr;
      logic [1:0]          col_en;
      logic [2*WORD_W-1:0] data;
   } wr_req_t;

   wr_req_t                 wr;
   vuad_pkg::index_t        rd_idx;
   vuad_pkg::entry_t        rd_entry;
   vuad_pkg::word_sel_t     rd_word;
   logic                    rd_accept;
   vuad_pkg::entry_t        wr_entry;
   vuad_pkg::word_sel_t     wr_word;
   vuad_pkg::word_en_t      wr_word_en;
   vuad_pkg::sub_sel_t      wr_sub;
   logic [vuad_pkg::NUM_SUB-1:0] wr_hit;

   ////////////////////////////////////////
   // read side decode
   ////////////////////////////////////////

   assign rd_idx    = rd_req.addr_sel ? rd_req.addr1 : rd_req.addr2;
   assign rd_entry  = rd_idx[6:2];
   assign rd_word   = rd_idx[1:0];

   // a request only moves when the response path can take it
   assign rd_req_ready = advance;
   assign rd_accept    = rd_req_valid & advance;

   ////////////////////////////////////////
   // write side decode
   ////////////////////////////////////////

   assign wr         = wr_req;
   assign wr_entry   = wr.addr[6:2];
   assign wr_word    = wr.addr[1:0];
   assign wr_word_en = vuad_pkg::word_en_t'(1) << wr_word;
   assign wr_sub     = wr.addr[9:7];
   assign wr_data    = wr.data;

   // per-subarray fan out
   for (genvar i = 0; i < vuad_pkg::NUM_SUB; i++) begin : g_sub
      localparam vuad_pkg::sub_sel_t SUB_NUM = vuad_pkg::sub_sel_t'(i);

      assign wr_hit[i] = wr_valid && (wr_sub == SUB_NUM);

      assign sub_ctl[i].rd_en      = rd_accept && (rd_idx[7] == SUB_NUM[0]);  // odd/even
      assign sub_ctl[i].rd_entry   = rd_entry;
      assign sub_ctl[i].wr_entry   = wr_entry;
      assign sub_ctl[i].wr_word_en = wr_word_en;
      assign sub_ctl[i].wr_col_en  = wr_hit[i] ? wr.col_en : 2'b00;
   end

   ////////////////////////////////////////
   // stage c1 registers
   ////////////////////////////////////////

   // selects travel with the subarray read registers
   always_ff @(posedge rclk) begin
      if (rd_accept) begin
         mux_sel.word_en <= vuad_pkg::word_en_t'(1) << rd_word;
         mux_sel.odd     <= rd_idx[7];
         mux_sel.pair    <= vuad_pkg::pair_sel_t'(1) << rd_idx[9:8];
      end
   end

   // c1 drains into the response register whenever advance is high
   always_ff @(posedge rclk) begin
      if (reset) begin
         rd_valid_c1 <= 1'b0;
      end else if (advance) begin
         rd_valid_c1 <= rd_accept;
      end
   end

   // one write lands in at most one subarray
   a_wr_onehot : assert property (@(posedge rclk) disable iff (reset)
      $onehot0({sub_ctl[7].wr_col_en != 2'b00, sub_ctl[6].wr_col_en != 2'b00,
                sub_ctl[5].wr_col_en != 2'b00, sub_ctl[4].wr_col_en != 2'b00,
                sub_ctl[3].wr_col_en != 2'b00, sub_ctl[2].wr_col_en != 2'b00,
                sub_ctl[1].wr_col_en != 2'b00, sub_ctl[0].wr_col_en != 2'b00}))
      else $error("vuad_ctl: write enables hit more than one subarray");

endmodule

/* src/vuad_pkg.sv */
/*
 * vuad state array package
 * line index fields, vector types and the request and control structs
 */
package vuad_pkg;

   ////////////////////////////////////////
   // array geometry
   ////////////////////////////////////////

   localparam int NUM_SUB   = 8;            // fixed by index bits 9:7
   localparam int NUM_PAIR  = NUM_SUB / 2;  // even/odd pairs, index bits 9:8
   localparam int NUM_ENTRY = 32;           // index bits 6:2
   localparam int NUM_WORD  = 4;            // index bits 1:0

   ////////////////////////////////////////
   // index fields
   ////////////////////////////////////////

   typedef logic [9:0]          index_t;    // full line index
   typedef logic [4:0]          entry_t;    // bits 6:2
   typedef logic [1:0]          word_sel_t; // bits 1:0
   typedef logic [NUM_WORD-1:0] word_en_t;  // one-hot word
   typedef logic [2:0]          sub_sel_t;  // bits 9:7
   typedef logic [NUM_PAIR-1:0] pair_sel_t; // one-hot pair

   ////////////////////////////////////////
   // structs
   ////////////////////////////////////////

   // read request, two address sources
   typedef struct packed {
      index_t addr1;
      index_t addr2;
      logic   addr_sel;  // 1 picks addr1
   } rd_req_t;

   // per-subarray control, one copy for each of the eight
   typedef struct packed {
      logic       rd_en;
      entry_t     rd_entry;
      entry_t     wr_entry;
      word_en_t   wr_word_en;
      logic [1:0] wr_col_en;  // bit 0 low column, bit 1 high column
   } sub_ctl_t;

   // read mux selects, registered with the subarray outputs
   typedef struct packed {
      word_en_t  word_en;
      logic      odd;
      pair_sel_t pair;
   } mux_sel_t;

endpackage
